// File: src/div_pkg.sv
/*
 * Shared definitions of the division unit:
 * data, tag and index widths, station depth,
 * operation codes, exception codes and iteration count
 */
package div_pkg;

    // Datapath width
    localparam int XLEN = 64;

    // Reservation station size
    localparam int RS_DEPTH = 8;
    localparam int RS_IDX_LEN = 3;

    // Reorder buffer tag, also used for operand tags
    localparam int ROB_IDX_LEN = 4;

    // Operation codes seen by the divider
    localparam int EU_CTL_LEN = 4;
    localparam logic [EU_CTL_LEN-1:0] DIV_OP_DIV = 4'd0;
    localparam logic [EU_CTL_LEN-1:0] DIV_OP_DIVU = 4'd1;
    localparam logic [EU_CTL_LEN-1:0] DIV_OP_REM = 4'd2;
    localparam logic [EU_CTL_LEN-1:0] DIV_OP_REMU = 4'd3;

    // Exception codes
    localparam int EXCEPT_LEN = 2;
    localparam logic [EXCEPT_LEN-1:0] EXC_NONE = 2'd0;
    localparam logic [EXCEPT_LEN-1:0] EXC_DIV_BY_ZERO = 2'd1;

    // One quotient bit per iteration
    localparam int DIV_STEPS = XLEN;

endpackage

// File: src/div_eu.sv
/*
 * Iterative divider for DIV, DIVU, REM and REMU:
 * restoring shift-subtract core, sign handling,
 * zero-divisor special result and registered result port
 */
module div_eu (
    input  logic                             clk_i,
    input  logic                             rst_n_i,
    input  logic                             flush_i,
    // Operation from the station
    input  logic                             eu_valid_i,
    output logic                             eu_ready_o,
    input  logic [div_pkg::EU_CTL_LEN-1:0]   eu_ctl_i,
    input  logic [div_pkg::XLEN-1:0]         eu_rs1_i,
    input  logic [div_pkg::XLEN-1:0]         eu_rs2_i,
    input  logic [div_pkg::RS_IDX_LEN-1:0]   eu_entry_idx_i,
    // Result back to the station
    output logic                             eu_res_valid_o,
    input  logic                             eu_res_ready_i,
    output logic [div_pkg::RS_IDX_LEN-1:0]   eu_res_entry_idx_o,
    output logic [div_pkg::XLEN-1:0]         eu_result_o,
    output logic                             eu_except_raised_o,
    output logic [div_pkg::EXCEPT_LEN-1:0]   eu_except_code_o
);
    import div_pkg::*;

    // Control flags, at most one set at a time
    logic run_q;
    logic fin_q;
    logic done_q;
    logic [$clog2(DIV_STEPS)-1:0] step_cnt_q;

    // Iteration registers
    logic [XLEN-1:0] quo_q;
    logic [XLEN-1:0] rem_q;
    logic [XLEN-1:0] dvsr_q;
    logic [RS_IDX_LEN-1:0] idx_q;
    logic op_rem_q;
    logic neg_q_q;
    logic neg_r_q;
    logic zero_q;

    logic accept;
    logic is_signed;
    logic is_rem;
    logic rs2_zero;
    logic [XLEN-1:0] abs_rs1;
    logic [XLEN-1:0] abs_rs2;
    logic [XLEN:0] rem_shift;
    logic [XLEN:0] diff;
    logic [XLEN-1:0] quo_fix;
    logic [XLEN-1:0] rem_fix;
    logic [XLEN-1:0] result_d;

    // Idle only when no flag is set
    assign eu_ready_o = !(run_q || fin_q || done_q);
    assign eu_res_valid_o = done_q;
    assign accept = eu_valid_i && eu_ready_o && !flush_i;

    // Decode of the incoming operation
    assign is_signed = (eu_ctl_i == DIV_OP_DIV) || (eu_ctl_i == DIV_OP_REM);
    assign is_rem = (eu_ctl_i == DIV_OP_REM) || (eu_ctl_i == DIV_OP_REMU);
    assign rs2_zero = (eu_rs2_i == '0);

    // Magnitudes, unsigned operands pass as they are
    assign abs_rs1 = (is_signed && eu_rs1_i[XLEN-1]) ? -eu_rs1_i : eu_rs1_i;
    assign abs_rs2 = (is_signed && eu_rs2_i[XLEN-1]) ? -eu_rs2_i : eu_rs2_i;

    // One restoring step: shift in next dividend bit, try subtract
    assign rem_shift = {rem_q, quo_q[XLEN-1]};
    assign diff = rem_shift - {1'b0, dvsr_q};

    // Sign fix-up after the last step
    // Overflow case wraps back to the most negative value by itself
    assign quo_fix = neg_q_q ? -quo_q : quo_q;
    assign rem_fix = neg_r_q ? -rem_q : rem_q;

    // Zero divisor: quo_q still holds the raw dividend
    always_comb begin
        if (zero_q) begin
            result_d = op_rem_q ? quo_q : '1;
        end else begin
            result_d = op_rem_q ? rem_fix : quo_fix;
        end
    end

    // Sequencing
    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            run_q <= 1'b0;
            fin_q <= 1'b0;
            done_q <= 1'b0;
            step_cnt_q <= '0;
        end else if (flush_i) begin
            run_q <= 1'b0;
            fin_q <= 1'b0;
            done_q <= 1'b0;
            step_cnt_q <= '0;
        end else begin
            if (accept) begin
                // Zero divisor goes straight to the finish cycle
                run_q <= !rs2_zero;
                fin_q <= rs2_zero;
                step_cnt_q <= '0;
            end
            if (run_q) begin
                step_cnt_q <= step_cnt_q + 1'b1;
                if (step_cnt_q == $bits(step_cnt_q)'(DIV_STEPS - 1)) begin
                    run_q <= 1'b0;
                    fin_q <= 1'b1;
                end
            end
            if (fin_q) begin
                fin_q <= 1'b0;
                done_q <= 1'b1;
            end
            // Hold the result until the station takes it
            if (done_q && eu_res_ready_i) begin
                done_q <= 1'b0;
            end
        end
    end

    // Operand capture and iteration
    always_ff @(posedge clk_i) begin
        if (accept) begin
            quo_q <= rs2_zero ? eu_rs1_i : abs_rs1;
            rem_q <= '0;
            dvsr_q <= abs_rs2;
            idx_q <= eu_entry_idx_i;
            op_rem_q <= is_rem;
            neg_q_q <= is_signed && (eu_rs1_i[XLEN-1] ^ eu_rs2_i[XLEN-1]);
            // Remainder takes the sign of the dividend
            neg_r_q <= is_signed && eu_rs1_i[XLEN-1];
            zero_q <= rs2_zero;
        end else if (run_q) begin
            if (!diff[XLEN]) begin
                rem_q <= diff[XLEN-1:0];
                quo_q <= {quo_q[XLEN-2:0], 1'b1};
            end else begin
                rem_q <= rem_shift[XLEN-1:0];
                quo_q <= {quo_q[XLEN-2:0], 1'b0};
            end
        end
    end

    // Output register, loaded once per operation
    always_ff @(posedge clk_i) begin
        if (fin_q) begin
            eu_result_o <= result_d;
            eu_res_entry_idx_o <= idx_q;
            eu_except_raised_o <= zero_q;
            eu_except_code_o <= zero_q ? EXC_DIV_BY_ZERO : EXC_NONE;
        end
    end

    // A stalled result keeps all its fields
    assert property (@(posedge clk_i) disable iff (!rst_n_i)
        eu_res_valid_o && !eu_res_ready_i && !flush_i |=>
            eu_res_valid_o && $stable(eu_result_o) && $stable(eu_res_entry_idx_o)
            && $stable(eu_except_raised_o) && $stable(eu_except_code_o));

    // An accepted operation blocks new ones for at least its minimum latency
    assert property (@(posedge clk_i) disable iff (!rst_n_i || flush_i)
        eu_valid_i && eu_ready_o |=> !eu_ready_o ##1 !eu_ready_o);

endmodule

// File: src/div_rs.sv
/*
 * Reservation station of the division path:
 * entry storage, write-back operand wake-up,
 * lowest-index dispatch and registered result port
 */
module div_rs (
    input  logic                             clk_i,
    input  logic                             rst_n_i,
    input  logic                             flush_i,
    // Issue
    input  logic                             issue_valid_i,
    output logic                             issue_ready_o,
    input  logic [div_pkg::EU_CTL_LEN-1:0]   issue_ctl_i,
    input  logic [div_pkg::ROB_IDX_LEN-1:0]  issue_rob_tag_i,
    input  logic                             rs1_ready_i,
    input  logic [div_pkg::ROB_IDX_LEN-1:0]  rs1_tag_i,
    input  logic [div_pkg::XLEN-1:0]         rs1_value_i,
    input  logic                             rs2_ready_i,
    input  logic [div_pkg::ROB_IDX_LEN-1:0]  rs2_tag_i,
    input  logic [div_pkg::XLEN-1:0]         rs2_value_i,
    // Write-back snoop
    input  logic                             wb_valid_i,
    input  logic [div_pkg::ROB_IDX_LEN-1:0]  wb_tag_i,
    input  logic [div_pkg::XLEN-1:0]         wb_value_i,
    // To the divider
    output logic                             eu_valid_o,
    input  logic                             eu_ready_i,
    output logic [div_pkg::EU_CTL_LEN-1:0]   eu_ctl_o,
    output logic [div_pkg::XLEN-1:0]         eu_rs1_o,
    output logic [div_pkg::XLEN-1:0]         eu_rs2_o,
    output logic [div_pkg::RS_IDX_LEN-1:0]   eu_entry_idx_o,
    // From the divider
    input  logic                             eu_res_valid_i,
    output logic                             eu_res_ready_o,
    input  logic [div_pkg::RS_IDX_LEN-1:0]   eu_res_entry_idx_i,
    input  logic [div_pkg::XLEN-1:0]         eu_result_i,
    input  logic                             eu_except_raised_i,
    input  logic [div_pkg::EXCEPT_LEN-1:0]   eu_except_code_i,
    // Result port
    output logic                             res_valid_o,
    input  logic                             res_ready_i,
    output logic [div_pkg::ROB_IDX_LEN-1:0]  res_rob_tag_o,
    output logic [div_pkg::XLEN-1:0]         res_value_o,
    output logic                             res_except_o,
    output logic [div_pkg::EXCEPT_LEN-1:0]   res_except_code_o
);
    import div_pkg::*;

    // Entry state
    logic [RS_DEPTH-1:0] busy_q;
    logic [RS_DEPTH-1:0] disp_q;
    logic [RS_DEPTH-1:0] rs1_rdy_q;
    logic [RS_DEPTH-1:0] rs2_rdy_q;
    logic [EU_CTL_LEN-1:0] ctl_q [RS_DEPTH];
    logic [ROB_IDX_LEN-1:0] rob_tag_q [RS_DEPTH];
    logic [ROB_IDX_LEN-1:0] rs1_tag_q [RS_DEPTH];
    logic [ROB_IDX_LEN-1:0] rs2_tag_q [RS_DEPTH];
    logic [XLEN-1:0] rs1_val_q [RS_DEPTH];
    logic [XLEN-1:0] rs2_val_q [RS_DEPTH];

    logic [RS_IDX_LEN-1:0] free_idx;
    logic [RS_IDX_LEN-1:0] disp_idx;
    logic [RS_IDX_LEN-1:0] res_idx_q;
    logic [RS_DEPTH-1:0] alloc;
    logic [RS_DEPTH-1:0] wake1;
    logic [RS_DEPTH-1:0] wake2;
    logic [RS_DEPTH-1:0] cand;
    logic issue_fire;
    logic issue_wake1;
    logic issue_wake2;
    logic res_load;
    logic res_fire;

    assign issue_ready_o = ~&busy_q;
    assign issue_fire = issue_valid_i && issue_ready_o;
    // Write-back in the issue cycle also counts
    assign issue_wake1 = wb_valid_i && (wb_tag_i == rs1_tag_i);
    assign issue_wake2 = wb_valid_i && (wb_tag_i == rs2_tag_i);

    // Result handshakes, back-pressure passes straight to the divider
    assign eu_res_ready_o = res_ready_i;
    assign res_load = eu_res_valid_i && res_ready_i;
    assign res_fire = res_valid_o && res_ready_i;

    // Free slot, dispatch pick and snoop hits
    always_comb begin
        free_idx = '0;
        disp_idx = '0;
        for (int i = RS_DEPTH - 1; i >= 0; i--) begin
            cand[i] = busy_q[i] && !disp_q[i] && rs1_rdy_q[i] && rs2_rdy_q[i];
            wake1[i] = !rs1_rdy_q[i] && wb_valid_i && (wb_tag_i == rs1_tag_q[i]);
            wake2[i] = !rs2_rdy_q[i] && wb_valid_i && (wb_tag_i == rs2_tag_q[i]);
            // Descending scan leaves the lowest index
            if (!busy_q[i]) begin
                free_idx = RS_IDX_LEN'(i);
            end
            if (cand[i]) begin
                disp_idx = RS_IDX_LEN'(i);
            end
        end
        for (int i = 0; i < RS_DEPTH; i++) begin
            alloc[i] = issue_fire && (free_idx == RS_IDX_LEN'(i));
        end
    end

    // Dispatch port reads the picked entry
    assign eu_valid_o = |cand;
    assign eu_ctl_o = ctl_q[disp_idx];
    assign eu_rs1_o = rs1_val_q[disp_idx];
    assign eu_rs2_o = rs2_val_q[disp_idx];
    assign eu_entry_idx_o = disp_idx;

    // Entry control and result valid
    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            busy_q <= '0;
            disp_q <= '0;
            rs1_rdy_q <= '0;
            rs2_rdy_q <= '0;
            res_valid_o <= 1'b0;
        end else if (flush_i) begin
            busy_q <= '0;
            disp_q <= '0;
            res_valid_o <= 1'b0;
        end else begin
            for (int i = 0; i < RS_DEPTH; i++) begin
                if (alloc[i]) begin
                    busy_q[i] <= 1'b1;
                    disp_q[i] <= 1'b0;
                    rs1_rdy_q[i] <= rs1_ready_i || issue_wake1;
                    rs2_rdy_q[i] <= rs2_ready_i || issue_wake2;
                end else begin
                    rs1_rdy_q[i] <= rs1_rdy_q[i] || wake1[i];
                    rs2_rdy_q[i] <= rs2_rdy_q[i] || wake2[i];
                end
            end
            if (eu_valid_o && eu_ready_i) begin
                disp_q[disp_idx] <= 1'b1;
            end
            // Entry lives until its result leaves the port
            if (res_fire) begin
                busy_q[res_idx_q] <= 1'b0;
            end
            if (res_load) begin
                res_valid_o <= 1'b1;
            end else if (res_fire) begin
                res_valid_o <= 1'b0;
            end
        end
    end

    // Entry payload
    always_ff @(posedge clk_i) begin
        for (int i = 0; i < RS_DEPTH; i++) begin
            if (alloc[i]) begin
                ctl_q[i] <= issue_ctl_i;
                rob_tag_q[i] <= issue_rob_tag_i;
                rs1_tag_q[i] <= rs1_tag_i;
                rs2_tag_q[i] <= rs2_tag_i;
                rs1_val_q[i] <= rs1_ready_i ? rs1_value_i : wb_value_i;
                rs2_val_q[i] <= rs2_ready_i ? rs2_value_i : wb_value_i;
            end else begin
                if (wake1[i]) begin
                    rs1_val_q[i] <= wb_value_i;
                end
                if (wake2[i]) begin
                    rs2_val_q[i] <= wb_value_i;
                end
            end
        end
    end

    // Result register, ROB tag looked up by entry index
    always_ff @(posedge clk_i) begin
        if (res_load) begin
            res_idx_q <= eu_res_entry_idx_i;
            res_rob_tag_o <= rob_tag_q[eu_res_entry_idx_i];
            res_value_o <= eu_result_i;
            res_except_o <= eu_except_raised_i;
            res_except_code_o <= eu_except_code_i;
        end
    end

    // An accepted issue lands in a free entry that is busy afterwards
    assert property (@(posedge clk_i) disable iff (!rst_n_i)
        issue_fire && !flush_i |-> !busy_q[free_idx] ##1 busy_q[$past(free_idx)]);

    // The divider only returns entries this station sent out
    assert property (@(posedge clk_i) disable iff (!rst_n_i)
        eu_res_valid_i |-> busy_q[eu_res_entry_idx_i] && disp_q[eu_res_entry_idx_i]);

endmodule

// File: src/div_rs_unit.sv
/*
 * Division path top level:
 * reservation station and iterative divider
 */
module div_rs_unit (
    input  logic                             clk_i,
    input  logic                             rst_n_i,
    input  logic                             flush_i,
    // Issue
    input  logic                             issue_valid_i,
    output logic                             issue_ready_o,
    input  logic [div_pkg::EU_CTL_LEN-1:0]   issue_ctl_i,
    input  logic [div_pkg::ROB_IDX_LEN-1:0]  issue_rob_tag_i,
    input  logic                             rs1_ready_i,
    input  logic [div_pkg::ROB_IDX_LEN-1:0]  rs1_tag_i,
    input  logic [div_pkg::XLEN-1:0]         rs1_value_i,
    input  logic                             rs2_ready_i,
    input  logic [div_pkg::ROB_IDX_LEN-1:0]  rs2_tag_i,
    input  logic [div_pkg::XLEN-1:0]         rs2_value_i,
    // Write-back snoop
    input  logic                             wb_valid_i,
    input  logic [div_pkg::ROB_IDX_LEN-1:0]  wb_tag_i,
    input  logic [div_pkg::XLEN-1:0]         wb_value_i,
    // Result port
    output logic                             res_valid_o,
    input  logic                             res_ready_i,
    output logic [div_pkg::ROB_IDX_LEN-1:0]  res_rob_tag_o,
    output logic [div_pkg::XLEN-1:0]         res_value_o,
    output logic                             res_except_o,
    output logic [div_pkg::EXCEPT_LEN-1:0]   res_except_code_o
);
    import div_pkg::*;

    // Station to divider
    logic eu_valid;
    logic eu_ready;
    logic [EU_CTL_LEN-1:0] eu_ctl;
    logic [XLEN-1:0] eu_rs1;
    logic [XLEN-1:0] eu_rs2;
    logic [RS_IDX_LEN-1:0] eu_entry_idx;

    // Divider to station
    logic eu_res_valid;
    logic eu_res_ready;
    logic [RS_IDX_LEN-1:0] eu_res_entry_idx;
    logic [XLEN-1:0] eu_result;
    logic eu_except_raised;
    logic [EXCEPT_LEN-1:0] eu_except_code;

    div_rs u_rs (
        .clk_i, .rst_n_i, .flush_i,
        .issue_valid_i, .issue_ready_o, .issue_ctl_i, .issue_rob_tag_i,
        .rs1_ready_i, .rs1_tag_i, .rs1_value_i,
        .rs2_ready_i, .rs2_tag_i, .rs2_value_i,
        .wb_valid_i, .wb_tag_i, .wb_value_i,
        .eu_valid_o(eu_valid), .eu_ready_i(eu_ready), .eu_ctl_o(eu_ctl),
        .eu_rs1_o(eu_rs1), .eu_rs2_o(eu_rs2), .eu_entry_idx_o(eu_entry_idx),
        .eu_res_valid_i(eu_res_valid), .eu_res_ready_o(eu_res_ready),
        .eu_res_entry_idx_i(eu_res_entry_idx), .eu_result_i(eu_result),
        .eu_except_raised_i(eu_except_raised), .eu_except_code_i(eu_except_code),
        .res_valid_o, .res_ready_i, .res_rob_tag_o, .res_value_o,
        .res_except_o, .res_except_code_o
    );

    div_eu u_eu (
        .clk_i, .rst_n_i, .flush_i,
        .eu_valid_i(eu_valid), .eu_ready_o(eu_ready), .eu_ctl_i(eu_ctl),
        .eu_rs1_i(eu_rs1), .eu_rs2_i(eu_rs2), .eu_entry_idx_i(eu_entry_idx),
        .eu_res_valid_o(eu_res_valid), .eu_res_ready_i(eu_res_ready),
        .eu_res_entry_idx_o(eu_res_entry_idx), .eu_result_o(eu_result),
        .eu_except_raised_o(eu_except_raised), .eu_except_code_o(eu_except_code)
    );

endmodule

// File: test/tb_div_rs_unit.sv
/*
 * Directed testbench of the division path: clock, reset, watchdog,
 * reference model, scoreboard by ROB tag, compare tasks and tests
 */
module tb_div_rs_unit;
    timeunit 1ns;
    timeprecision 1ns;
    import div_pkg::*;

    // Every op costs at most one full divide plus handshakes
    localparam int NUM_OPS = 41;
    localparam int MAX_CYCLES = NUM_OPS * (DIV_STEPS + 6) + 500;
    localparam int NUM_TAGS = 2 ** ROB_IDX_LEN;

    logic clk_i;
    logic rst_n_i;
    logic flush_i;
    logic issue_valid_i;
    logic issue_ready_o;
    logic [EU_CTL_LEN-1:0] issue_ctl_i;
    logic [ROB_IDX_LEN-1:0] issue_rob_tag_i;
    logic rs1_ready_i;
    logic [ROB_IDX_LEN-1:0] rs1_tag_i;
    logic [XLEN-1:0] rs1_value_i;
    logic rs2_ready_i;
    logic [ROB_IDX_LEN-1:0] rs2_tag_i;
    logic [XLEN-1:0] rs2_value_i;
    logic wb_valid_i;
    logic [ROB_IDX_LEN-1:0] wb_tag_i;
    logic [XLEN-1:0] wb_value_i;
    logic res_valid_o;
    logic res_ready_i;
    logic [ROB_IDX_LEN-1:0] res_rob_tag_o;
    logic [XLEN-1:0] res_value_o;
    logic res_except_o;
    logic [EXCEPT_LEN-1:0] res_except_code_o;

    // Scoreboard, results may return out of order
    logic exp_valid [NUM_TAGS];
    logic [XLEN-1:0] exp_value [NUM_TAGS];
    logic exp_zero [NUM_TAGS];
    int outstanding;
    int cycle_cnt;

    div_rs_unit dut (.*);

    always #20 clk_i = ~clk_i;

    task automatic stop_on_error(input string msg);
        $display("%s", msg);
        $display("Testbench failed");
        $fatal(1, "simulation stopped");
    endtask

    task automatic check_value(input string name, input logic [XLEN-1:0] exp,
                               input logic [XLEN-1:0] act);
        if (act !== exp) begin
            stop_on_error($sformatf("FAIL t=%0t %s expected %h actual %h", $time, name, exp, act));
        end
    endtask

    task automatic check_tag(input string name, input logic [ROB_IDX_LEN-1:0] exp,
                             input logic [ROB_IDX_LEN-1:0] act);
        if (act !== exp) begin
            stop_on_error($sformatf("FAIL t=%0t %s expected %0d actual %0d", $time, name, exp, act));
        end
    endtask

    task automatic check_exc(input logic exp_flag, input logic [EXCEPT_LEN-1:0] exp_code,
                             input logic act_flag, input logic [EXCEPT_LEN-1:0] act_code);
        if (act_flag !== exp_flag || act_code !== exp_code) begin
            stop_on_error($sformatf(
                "FAIL t=%0t res_except_o/res_except_code_o expected %b/%0d actual %b/%0d",
                $time, exp_flag, exp_code, act_flag, act_code));
        end
    endtask

    task automatic check_flag(input string name, input logic exp, input logic act);
        if (act !== exp) begin
            stop_on_error($sformatf("FAIL t=%0t %s expected %b actual %b", $time, name, exp, act));
        end
    endtask

    // RISC-V division rules
    function automatic logic [XLEN-1:0] ref_div(input logic [EU_CTL_LEN-1:0] ctl,
                                                input logic [XLEN-1:0] a, input logic [XLEN-1:0] b);
        logic signed [XLEN-1:0] sa;
        logic signed [XLEN-1:0] sb;
        logic [XLEN-1:0] min_neg;
        sa = a;
        sb = b;
        min_neg = {1'b1, {(XLEN-1){1'b0}}};
        // Zero divisor: all ones as quotient, dividend as remainder
        if (b == '0) begin
            return (ctl == DIV_OP_DIV || ctl == DIV_OP_DIVU) ? '1 : a;
        end
        // Signed overflow keeps the dividend as quotient, no remainder
        if (a == min_neg && b == '1 && ctl == DIV_OP_DIV) begin
            return min_neg;
        end
        if (a == min_neg && b == '1 && ctl == DIV_OP_REM) begin
            return '0;
        end
        case (ctl)
            DIV_OP_DIV: return sa / sb;
            DIV_OP_REM: return sa % sb;
            DIV_OP_DIVU: return a / b;
            default: return a % b;
        endcase
    endfunction

    // Random magnitude and sign
    function automatic logic [XLEN-1:0] rand_word();
        logic [XLEN-1:0] v;
        v = {$urandom, $urandom} >> ($urandom % XLEN);
        return ($urandom % 2) ? -v : v;
    endfunction

    function automatic logic [XLEN-1:0] rand_divisor();
        logic [XLEN-1:0] v;
        v = rand_word();
        return (v == '0) ? XLEN'(3) : v;
    endfunction

    // Inputs change 2 ns after the rising edge
    task automatic step();
        @(posedge clk_i);
        #2;
    endtask

    task automatic expect_result(input logic [ROB_IDX_LEN-1:0] tag,
                                 input logic [EU_CTL_LEN-1:0] ctl,
                                 input logic [XLEN-1:0] a, input logic [XLEN-1:0] b);
        exp_valid[tag] = 1'b1;
        exp_value[tag] = ref_div(ctl, a, b);
        exp_zero[tag] = (b == '0);
        outstanding++;
    endtask

    // Held until the station accepts it
    task automatic issue_raw(input logic [EU_CTL_LEN-1:0] ctl, input logic [ROB_IDX_LEN-1:0] tag,
                             input logic r1, input logic [ROB_IDX_LEN-1:0] t1,
                             input logic [XLEN-1:0] v1,
                             input logic r2, input logic [ROB_IDX_LEN-1:0] t2,
                             input logic [XLEN-1:0] v2);
        issue_valid_i = 1'b1;
        issue_ctl_i = ctl;
        issue_rob_tag_i = tag;
        rs1_ready_i = r1;
        rs1_tag_i = t1;
        rs1_value_i = v1;
        rs2_ready_i = r2;
        rs2_tag_i = t2;
        rs2_value_i = v2;
        while (!issue_ready_o) begin
            step();
        end
        step();
        issue_valid_i = 1'b0;
    endtask

    task automatic issue_op(input logic [EU_CTL_LEN-1:0] ctl, input logic [ROB_IDX_LEN-1:0] tag,
                            input logic [XLEN-1:0] a, input logic [XLEN-1:0] b);
        expect_result(tag, ctl, a, b);
        issue_raw(ctl, tag, 1'b1, '0, a, 1'b1, '0, b);
    endtask

    task automatic send_wb(input logic [ROB_IDX_LEN-1:0] tag, input logic [XLEN-1:0] value);
        wb_valid_i = 1'b1;
        wb_tag_i = tag;
        wb_value_i = value;
        step();
        wb_valid_i = 1'b0;
    endtask

    task automatic drain();
        while (outstanding != 0) begin
            step();
        end
    endtask

    task automatic basic_ops();
        issue_op(DIV_OP_DIV, 4'd0, -XLEN'(100), XLEN'(7));
        issue_op(DIV_OP_DIVU, 4'd1, XLEN'(100), XLEN'(7));
        issue_op(DIV_OP_REM, 4'd2, -XLEN'(100), XLEN'(7));
        issue_op(DIV_OP_REMU, 4'd3, '1, XLEN'(3));
        issue_op(DIV_OP_DIV, 4'd4, XLEN'(7), -XLEN'(2));
        issue_op(DIV_OP_REM, 4'd5, XLEN'(7), -XLEN'(2));
        drain();
        for (int i = 0; i < 8; i++) begin
            issue_op(EU_CTL_LEN'(i % 4), ROB_IDX_LEN'(i), rand_word(), rand_divisor());
        end
        drain();
    endtask

    task automatic special_cases();
        issue_op(DIV_OP_DIV, 4'd0, -XLEN'(5), '0);
        issue_op(DIV_OP_DIVU, 4'd1, XLEN'(64'h0123_4567_89ab_cdef), '0);
        issue_op(DIV_OP_REM, 4'd2, -XLEN'(5), '0);
        issue_op(DIV_OP_REMU, 4'd3, XLEN'(64'h0123_4567_89ab_cdef), '0);
        // Most negative value by minus one
        issue_op(DIV_OP_DIV, 4'd4, {1'b1, {(XLEN-1){1'b0}}}, '1);
        issue_op(DIV_OP_REM, 4'd5, {1'b1, {(XLEN-1){1'b0}}}, '1);
        drain();
    endtask

    task automatic operand_wakeup();
        issue_raw(DIV_OP_DIV, 4'd0, 1'b0, 4'd9, '0, 1'b1, '0, XLEN'(7));
        issue_raw(DIV_OP_REMU, 4'd1, 1'b1, '0, XLEN'(1000), 1'b0, 4'd10, '0);
        // Divisor of the third op shows up on the bus in its issue cycle
        wb_valid_i = 1'b1;
        wb_tag_i = 4'd12;
        wb_value_i = XLEN'(9);
        issue_raw(DIV_OP_DIVU, 4'd2, 1'b0, 4'd11, '0, 1'b0, 4'd12, '0);
        wb_valid_i = 1'b0;
        // A premature dispatch would finish inside this window
        // No expectation yet, so any early result fails in the monitor
        repeat (DIV_STEPS + 10) begin
            step();
            check_flag("res_valid_o", 1'b0, res_valid_o);
        end
        expect_result(4'd0, DIV_OP_DIV, -XLEN'(1000), XLEN'(7));
        send_wb(4'd9, -XLEN'(1000));
        expect_result(4'd1, DIV_OP_REMU, XLEN'(1000), XLEN'(33));
        send_wb(4'd10, XLEN'(33));
        expect_result(4'd2, DIV_OP_DIVU, XLEN'(5000), XLEN'(9));
        send_wb(4'd11, XLEN'(5000));
        drain();
    endtask

    task automatic full_station_stall();
        logic [ROB_IDX_LEN-1:0] tag;
        logic [XLEN-1:0] val;
        logic exc;
        logic [EXCEPT_LEN-1:0] code;
        res_ready_i = 1'b0;
        for (int i = 0; i < RS_DEPTH; i++) begin
            check_flag("issue_ready_o", 1'b1, issue_ready_o);
            issue_op(EU_CTL_LEN'(i % 4), ROB_IDX_LEN'(i), rand_word(), rand_divisor());
        end
        check_flag("issue_ready_o", 1'b0, issue_ready_o);
        // First divide completes but cannot leave the divider
        repeat (DIV_STEPS + 8) begin
            step();
            check_flag("res_valid_o", 1'b0, res_valid_o);
        end
        res_ready_i = 1'b1;
        step();
        while (!res_valid_o) begin
            step();
        end
        // Stall the result port right after the first result appears
        res_ready_i = 1'b0;
        tag = res_rob_tag_o;
        val = res_value_o;
        exc = res_except_o;
        code = res_except_code_o;
        repeat (6) begin
            step();
            check_flag("res_valid_o", 1'b1, res_valid_o);
            check_tag("res_rob_tag_o", tag, res_rob_tag_o);
            check_value("res_value_o", val, res_value_o);
            check_exc(exc, code, res_except_o, res_except_code_o);
        end
        res_ready_i = 1'b1;
        drain();
    endtask

    task automatic flush_in_flight();
        // Fill the station so the flush has to free every entry
        for (int i = 0; i < RS_DEPTH; i++) begin
            issue_op(EU_CTL_LEN'(i % 4), ROB_IDX_LEN'(i), rand_word(), rand_divisor());
        end
        repeat (5) begin
            step();
        end
        check_flag("issue_ready_o", 1'b0, issue_ready_o);
        // Flushed ops never return
        for (int i = 0; i < NUM_TAGS; i++) begin
            exp_valid[i] = 1'b0;
        end
        outstanding = 0;
        flush_i = 1'b1;
        step();
        flush_i = 1'b0;
        repeat (DIV_STEPS + 10) begin
            check_flag("issue_ready_o", 1'b1, issue_ready_o);
            check_flag("res_valid_o", 1'b0, res_valid_o);
            step();
        end
        issue_op(DIV_OP_REM, 4'd3, rand_word(), rand_divisor());
        issue_op(DIV_OP_DIVU, 4'd4, rand_word(), rand_divisor());
        drain();
    endtask

    // Watchdog
    always @(posedge clk_i) begin
        cycle_cnt++;
        if (cycle_cnt >= MAX_CYCLES) begin
            stop_on_error($sformatf("Timeout, no progress after %0d cycles", cycle_cnt));
        end
    end

    // Handshake seen at the falling edge transfers on the next rising edge
    always @(negedge clk_i) begin
        if (rst_n_i && !flush_i && res_valid_o && res_ready_i) begin
            if (!exp_valid[res_rob_tag_o]) begin
                stop_on_error($sformatf("Result for ROB tag %0d was not expected", res_rob_tag_o));
            end
            check_value("res_value_o", exp_value[res_rob_tag_o], res_value_o);
            check_exc(exp_zero[res_rob_tag_o], exp_zero[res_rob_tag_o] ? EXC_DIV_BY_ZERO : EXC_NONE,
                      res_except_o, res_except_code_o);
            exp_valid[res_rob_tag_o] = 1'b0;
            outstanding--;
        end
    end

    initial begin
        void'($urandom(42));
        clk_i = 1'b0;
        rst_n_i = 1'b0;
        flush_i = 1'b0;
        issue_valid_i = 1'b0;
        issue_ctl_i = '0;
        issue_rob_tag_i = '0;
        rs1_ready_i = 1'b0;
        rs1_tag_i = '0;
        rs1_value_i = '0;
        rs2_ready_i = 1'b0;
        rs2_tag_i = '0;
        rs2_value_i = '0;
        wb_valid_i = 1'b0;
        wb_tag_i = '0;
        wb_value_i = '0;
        res_ready_i = 1'b1;
        outstanding = 0;
        cycle_cnt = 0;
        for (int i = 0; i < NUM_TAGS; i++) begin
            exp_valid[i] = 1'b0;
        end
        repeat (10) begin
            @(posedge clk_i);
        end
        #2;
        rst_n_i = 1'b1;
        check_flag("issue_ready_o", 1'b1, issue_ready_o);
        check_flag("res_valid_o", 1'b0, res_valid_o);
        basic_ops();
        special_cases();
        operand_wakeup();
        full_station_stall();
        flush_in_flight();
        $display("Testbench passed");
        $finish;
    end

endmodule

// File: div_rs_unit.f
src/div_pkg.sv
src/div_eu.sv
src/div_rs.sv
src/div_rs_unit.sv
test/tb_div_rs_unit.sv

// File: Makefile
# Verilator build and run of the division path testbench

VERILATOR ?= verilator
TOP       ?= tb_div_rs_unit
FILELIST  ?= div_rs_unit.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
PASS_MSG  ?= Testbench passed
VFLAGS    ?= --binary --timing --assert --timescale 1ns/1ns

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR) -o V$(TOP)

# The log decides: no pass line means failure
run: compile
	./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	grep -q "$(PASS_MSG)" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
